// ==== hw/micro_pkg.sv ====
package micro_pkg;

    localparam int REG_ADDR_W = 5;                  // Register index width
    localparam int WB_ADR_W   = 6;

    typedef logic [31:0]           word_t;
    typedef logic [REG_ADDR_W-1:0] reg_idx_t;
    typedef logic [5:0]            uaddr_t;
    typedef logic [3:0]            alu_op_t;
    typedef logic [WB_ADR_W-1:0]   wb_adr_t;

    localparam alu_op_t ALU_ADD   = 4'd0;
    localparam alu_op_t ALU_SUB   = 4'd1;
    localparam alu_op_t ALU_AND   = 4'd2;
    localparam alu_op_t ALU_OR    = 4'd3;
    localparam alu_op_t ALU_XOR   = 4'd4;
    localparam alu_op_t ALU_SLL   = 4'd5;
    localparam alu_op_t ALU_SRL   = 4'd6;
    localparam alu_op_t ALU_SRA   = 4'd7;
    localparam alu_op_t ALU_SLT   = 4'd8;
    localparam alu_op_t ALU_SLTU  = 4'd9;
    localparam alu_op_t ALU_MUL   = 4'd10;
    localparam alu_op_t ALU_PASSB = 4'd11;          // y = b, used by LUI

    localparam uaddr_t UA_RESERVED = 6'd0;          // All-zero opcode
    localparam uaddr_t UA_ADD      = 6'd1;
    localparam uaddr_t UA_SUB      = 6'd2;
    localparam uaddr_t UA_AND      = 6'd3;
    localparam uaddr_t UA_OR       = 6'd4;
    localparam uaddr_t UA_XOR      = 6'd5;
    localparam uaddr_t UA_SLL      = 6'd6;
    localparam uaddr_t UA_SRL      = 6'd7;
    localparam uaddr_t UA_SRA      = 6'd8;
    localparam uaddr_t UA_SLT      = 6'd9;
    localparam uaddr_t UA_SLTU     = 6'd10;
    localparam uaddr_t UA_LOAD     = 6'd11;
    localparam uaddr_t UA_STORE    = 6'd12;
    localparam uaddr_t UA_BRANCH   = 6'd13;
    localparam uaddr_t UA_ADDI     = 6'd14;
    localparam uaddr_t UA_SLTI     = 6'd15;
    localparam uaddr_t UA_SLTIU    = 6'd16;
    localparam uaddr_t UA_XORI     = 6'd17;
    localparam uaddr_t UA_ORI      = 6'd18;
    localparam uaddr_t UA_ANDI     = 6'd19;
    localparam uaddr_t UA_SLLI     = 6'd20;
    localparam uaddr_t UA_SRLI     = 6'd21;
    localparam uaddr_t UA_SRAI     = 6'd22;
    localparam uaddr_t UA_LUI      = 6'd23;
    localparam uaddr_t UA_AUIPC    = 6'd24;
    localparam uaddr_t UA_JAL      = 6'd25;
    localparam uaddr_t UA_JALR     = 6'd26;
    localparam uaddr_t UA_MUL      = 6'd27;
    localparam uaddr_t UA_XOR_M    = 6'd28;         // XOR with funct7 = 1
    localparam uaddr_t UA_OR_M     = 6'd29;         // OR with funct7 = 1
    localparam uaddr_t UA_ILLEGAL  = 6'd63;

    localparam wb_adr_t WB_ADR_INSN     = 6'd0;     // Write issues an instruction
    localparam wb_adr_t WB_ADR_STATUS   = 6'd1;     // Bit 0 is the illegal flag
    localparam wb_adr_t WB_ADR_REG_BASE = 6'd32;    // 32 + n reads xn

    typedef enum logic [2:0] {
        IDLE,
        DECODE,
        EXECUTE,
        WRITEBACK,
        ACK
    } seq_state_e;

endpackage

// ==== hw/address_mapper.sv ====
module address_mapper import micro_pkg::*; (
    input  logic [6:0] opcode,
    input  logic [2:0] funct3,
    input  logic [6:0] funct7,
    output uaddr_t     mapped_address
);

    localparam logic [6:0] OP_ZERO   = 7'b0000000;
    localparam logic [6:0] OP_R      = 7'b0110011;
    localparam logic [6:0] OP_LOAD   = 7'b0000011;
    localparam logic [6:0] OP_STORE  = 7'b0100011;
    localparam logic [6:0] OP_BRANCH = 7'b1100011;
    localparam logic [6:0] OP_I      = 7'b0010011;
    localparam logic [6:0] OP_LUI    = 7'b0110111;
    localparam logic [6:0] OP_AUIPC  = 7'b0010111;
    localparam logic [6:0] OP_JAL    = 7'b1101111;
    localparam logic [6:0] OP_JALR   = 7'b1100111;

    localparam logic [6:0] F7_BASE = 7'b0000000;
    localparam logic [6:0] F7_ALT  = 7'b0100000;    // SUB, SRA, SRAI
    localparam logic [6:0] F7_MUL  = 7'b0000001;

    always_comb begin
        mapped_address = UA_ILLEGAL;
        case (opcode)
            OP_ZERO: mapped_address = UA_RESERVED;
            OP_R: begin
                case (funct3)
                    3'b000: begin
                        if (funct7 == F7_BASE)
                            mapped_address = UA_ADD;
                        else if (funct7 == F7_ALT)
                            mapped_address = UA_SUB;
                        else if (funct7 == F7_MUL)
                            mapped_address = UA_MUL;
                    end
                    3'b111: mapped_address = UA_AND;    // funct7 not checked
                    3'b110: mapped_address = (funct7 == F7_MUL) ? UA_OR_M : UA_OR;
                    3'b100: mapped_address = (funct7 == F7_MUL) ? UA_XOR_M : UA_XOR;
                    3'b001: mapped_address = UA_SLL;
                    3'b101: begin
                        if (funct7 == F7_BASE)
                            mapped_address = UA_SRL;
                        else if (funct7 == F7_ALT)
                            mapped_address = UA_SRA;
                    end
                    3'b010: mapped_address = UA_SLT;
                    3'b011: mapped_address = UA_SLTU;
                    default: mapped_address = UA_ILLEGAL;
                endcase
            end
            OP_LOAD:   mapped_address = UA_LOAD;
            OP_STORE:  mapped_address = UA_STORE;
            OP_BRANCH: mapped_address = UA_BRANCH;   // All six branch forms
            OP_I: begin
                case (funct3)
                    3'b000: mapped_address = UA_ADDI;
                    3'b010: mapped_address = UA_SLTI;
                    3'b011: mapped_address = UA_SLTIU;
                    3'b100: mapped_address = UA_XORI;
                    3'b110: mapped_address = UA_ORI;
                    3'b111: mapped_address = UA_ANDI;
                    3'b001: mapped_address = UA_SLLI;
                    3'b101: begin
                        if (funct7 == F7_BASE)
                            mapped_address = UA_SRLI;
                        else if (funct7 == F7_ALT)
                            mapped_address = UA_SRAI;
                    end
                    default: mapped_address = UA_ILLEGAL;
                endcase
            end
            OP_LUI:   mapped_address = UA_LUI;
            OP_AUIPC: mapped_address = UA_AUIPC;
            OP_JAL:   mapped_address = UA_JAL;
            OP_JALR:  mapped_address = UA_JALR;
            default:  mapped_address = UA_ILLEGAL;
        endcase
    end

endmodule

// ==== hw/control_store.sv ====
module control_store import micro_pkg::*; (
    input  logic    clk,
    input  logic    reset,
    input  logic    load,
    input  uaddr_t  uaddr,
    output alu_op_t alu_op,
    output logic    use_imm,
    output logic    reg_write,
    output logic    illegal
);

    // Control word layout is {alu_op, use_imm, reg_write, illegal}
    logic [6:0] next_cw;

    function automatic logic [6:0] legal(alu_op_t op, logic imm);
        return {op, imm, 1'b1, 1'b0};
    endfunction

    always_comb begin
        case (uaddr)
            UA_ADD:   next_cw = legal(ALU_ADD, 1'b0);
            UA_SUB:   next_cw = legal(ALU_SUB, 1'b0);
            UA_AND:   next_cw = legal(ALU_AND, 1'b0);
            UA_OR:    next_cw = legal(ALU_OR, 1'b0);
            UA_XOR:   next_cw = legal(ALU_XOR, 1'b0);
            UA_SLL:   next_cw = legal(ALU_SLL, 1'b0);
            UA_SRL:   next_cw = legal(ALU_SRL, 1'b0);
            UA_SRA:   next_cw = legal(ALU_SRA, 1'b0);
            UA_SLT:   next_cw = legal(ALU_SLT, 1'b0);
            UA_SLTU:  next_cw = legal(ALU_SLTU, 1'b0);
            UA_MUL:   next_cw = legal(ALU_MUL, 1'b0);
            UA_ADDI:  next_cw = legal(ALU_ADD, 1'b1);
            UA_SLTI:  next_cw = legal(ALU_SLT, 1'b1);
            UA_SLTIU: next_cw = legal(ALU_SLTU, 1'b1);
            UA_XORI:  next_cw = legal(ALU_XOR, 1'b1);
            UA_ORI:   next_cw = legal(ALU_OR, 1'b1);
            UA_ANDI:  next_cw = legal(ALU_AND, 1'b1);
            UA_SLLI:  next_cw = legal(ALU_SLL, 1'b1);
            UA_SRLI:  next_cw = legal(ALU_SRL, 1'b1);
            UA_SRAI:  next_cw = legal(ALU_SRA, 1'b1);
            UA_LUI:   next_cw = legal(ALU_PASSB, 1'b1);     // Upper immediate straight through
            default:  next_cw = {ALU_ADD, 1'b0, 1'b0, 1'b1}; // Decoded only, flag it
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            alu_op    <= ALU_ADD;
            use_imm   <= 1'b0;
            reg_write <= 1'b0;
            illegal   <= 1'b0;
        end else if (load) begin
            {alu_op, use_imm, reg_write, illegal} <= next_cw;
        end
    end

endmodule

// ==== hw/alu.sv ====
module alu import micro_pkg::*; (
    input  alu_op_t op,
    input  word_t   a,
    input  word_t   b,
    output word_t   y
);

    logic [4:0] shamt;

    assign shamt = b[4:0];      // RV32I uses only five shift bits

    always_comb begin
        case (op)
            ALU_ADD: begin
                y = a + b;
            end
            ALU_SUB: begin
                y = a - b;
            end
            ALU_AND: begin
                y = a & b;
            end
            ALU_OR: begin
                y = a | b;
            end
            ALU_XOR: begin
                y = a ^ b;
            end
            ALU_SLL: begin
                y = a << shamt;
            end
            ALU_SRL: begin
                y = a >> shamt;
            end
            ALU_SRA: begin
                y = word_t'($signed(a) >>> shamt);
            end
            ALU_SLT: begin
                y = {31'b0, $signed(a) < $signed(b)};
            end
            ALU_SLTU: begin
                y = {31'b0, a < b};
            end
            ALU_MUL: begin
                y = a * b;          // Low half of the product
            end
            ALU_PASSB: begin
                y = b;
            end
            default: begin
                y = '0;
            end
        endcase
    end

endmodule

// ==== hw/register_file.sv ====
module register_file import micro_pkg::*; (
    input  logic     clk,
    input  logic     reset,
    input  reg_idx_t rs1,
    input  reg_idx_t rs2,
    input  reg_idx_t rd,
    input  logic     we,
    input  word_t    wd,
    output word_t    rd1,
    output word_t    rd2,
    input  reg_idx_t rdbg,
    output word_t    rdbg_data
);

    word_t regs [2**REG_ADDR_W];

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < 2**REG_ADDR_W; i++) begin
                regs[i] <= '0;
            end
        end else if (we && rd != '0) begin   // x0 stays zero
            regs[rd] <= wd;
        end
    end

    // Combinational reads, debug port serves the host
    assign rd1       = regs[rs1];
    assign rd2       = regs[rs2];
    assign rdbg_data = regs[rdbg];

endmodule

// ==== hw/micro_sequencer.sv ====
module micro_sequencer import micro_pkg::*; (
    input  logic       clk,
    input  logic       reset,
    input  logic       cyc,
    input  logic       stb,
    input  logic       we,
    input  wb_adr_t    adr,
    input  word_t      dat_w,
    input  word_t      alu_y,
    input  logic       reg_write,
    input  logic       illegal,
    input  word_t      rdbg_data,
    output logic       ack,
    output word_t      dat_r,
    output logic [6:0] opcode,
    output logic [2:0] funct3,
    output logic [6:0] funct7,
    output reg_idx_t   rs1,
    output reg_idx_t   rs2,
    output reg_idx_t   rd,
    output word_t      imm,
    output logic       cs_load,
    output logic       rf_we,
    output word_t      wb_data,
    output reg_idx_t   rdbg
);

    localparam logic [6:0] OP_LUI   = 7'b0110111;
    localparam logic [6:0] OP_AUIPC = 7'b0010111;

    seq_state_e state;
    word_t      ir;             // Instruction register
    wb_adr_t    req_adr;
    logic       req_we;
    logic       is_insn;
    logic       illegal_flag;   // Sticky until a status write

    assign is_insn = req_we && (req_adr == WB_ADR_INSN);

    always_ff @(posedge clk) begin
        if (state == IDLE && cyc && stb) begin
            req_adr <= adr;
            req_we  <= we;
            if (we && adr == WB_ADR_INSN)
                ir <= dat_w;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= IDLE;
        end else begin
            case (state)
                IDLE:      state <= (cyc && stb) ? DECODE : IDLE;
                DECODE:    state <= is_insn ? EXECUTE : ACK;    // Host access skips execute
                EXECUTE:   state <= WRITEBACK;
                WRITEBACK: state <= ACK;
                default:   state <= IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (reset)
            illegal_flag <= 1'b0;
        else if (state == WRITEBACK && illegal)
            illegal_flag <= 1'b1;
        else if (state == DECODE && req_we && req_adr == WB_ADR_STATUS)
            illegal_flag <= 1'b0;
    end

    // Instruction fields
    assign opcode = ir[6:0];
    assign rd     = ir[11:7];
    assign funct3 = ir[14:12];
    assign rs1    = ir[19:15];
    assign rs2    = ir[24:20];
    assign funct7 = ir[31:25];
    assign imm    = (opcode == OP_LUI || opcode == OP_AUIPC) ? {ir[31:12], 12'b0}
                                                             : {{20{ir[31]}}, ir[31:20]};

    assign cs_load = (state == DECODE) && is_insn;
    assign rf_we   = (state == WRITEBACK) && reg_write;
    assign wb_data = alu_y;
    assign ack     = (state == ACK);
    assign rdbg    = req_adr[REG_ADDR_W-1:0];

    always_comb begin
        if (req_adr >= WB_ADR_REG_BASE)
            dat_r = rdbg_data;
        else if (req_adr == WB_ADR_STATUS)
            dat_r = {31'b0, illegal_flag};
        else if (req_adr == WB_ADR_INSN)
            dat_r = ir;                             // Last issued instruction
        else
            dat_r = '0;
    end

endmodule

// ==== hw/micro_core.sv ====
module micro_core import micro_pkg::*; (
    input  logic    clk,
    input  logic    reset,
    input  logic    cyc,
    input  logic    stb,
    input  logic    we,
    input  wb_adr_t adr,
    input  word_t   dat_w,
    output word_t   dat_r,
    output logic    ack
);

    logic [6:0] opcode;
    logic [2:0] funct3;
    logic [6:0] funct7;
    reg_idx_t   rs1;
    reg_idx_t   rs2;
    reg_idx_t   rd;
    reg_idx_t   rdbg;
    word_t      imm;
    word_t      rd1;
    word_t      rd2;
    word_t      alu_y;
    word_t      wb_data;
    word_t      rdbg_data;
    uaddr_t     mapped_address;
    alu_op_t    alu_op;
    logic       use_imm;
    logic       reg_write;
    logic       illegal;
    logic       cs_load;
    logic       rf_we;

    micro_sequencer u_micro_sequencer (
        .clk       (clk),
        .reset     (reset),
        .cyc       (cyc),
        .stb       (stb),
        .we        (we),
        .adr       (adr),
        .dat_w     (dat_w),
        .alu_y     (alu_y),
        .reg_write (reg_write),
        .illegal   (illegal),
        .rdbg_data (rdbg_data),
        .ack       (ack),
        .dat_r     (dat_r),
        .opcode    (opcode),
        .funct3    (funct3),
        .funct7    (funct7),
        .rs1       (rs1),
        .rs2       (rs2),
        .rd        (rd),
        .imm       (imm),
        .cs_load   (cs_load),
        .rf_we     (rf_we),
        .wb_data   (wb_data),
        .rdbg      (rdbg)
    );

    address_mapper u_address_mapper (
        .opcode         (opcode),
        .funct3         (funct3),
        .funct7         (funct7),
        .mapped_address (mapped_address)
    );

    control_store u_control_store (
        .clk       (clk),
        .reset     (reset),
        .load      (cs_load),
        .uaddr     (mapped_address),
        .alu_op    (alu_op),
        .use_imm   (use_imm),
        .reg_write (reg_write),
        .illegal   (illegal)
    );

    alu u_alu (
        .op (alu_op),
        .a  (rd1),
        .b  (use_imm ? imm : rd2),  // Operand b source select
        .y  (alu_y)
    );

    register_file u_register_file (
        .clk       (clk),
        .reset     (reset),
        .rs1       (rs1),
        .rs2       (rs2),
        .rd        (rd),
        .we        (rf_we),
        .wd        (wb_data),
        .rd1       (rd1),
        .rd2       (rd2),
        .rdbg      (rdbg),
        .rdbg_data (rdbg_data)
    );

endmodule

// ==== tb/micro_core_checker.sv ====
module micro_core_checker import micro_pkg::*; (
    input logic    clk,
    input logic    reset,
    input logic    cyc,
    input logic    stb,
    input logic    we,
    input wb_adr_t adr,
    input logic    ack
);

    logic access;
    logic insn_write;

    assign access     = cyc && stb;
    assign insn_write = we && (adr == WB_ADR_INSN);     // Runs the full FSM path

    ack_one_cycle: assert property (@(posedge clk) disable iff (reset) ack |=> !ack)
        else $error("ack high for more than one cycle");

    ack_after_stb: assert property (@(posedge clk) disable iff (reset) ack |-> access)
        else $error("ack without an active strobe");

    insn_latency: assert property (@(posedge clk) disable iff (reset)
        $rose(access) && insn_write |-> !ack ##1 !ack ##1 !ack ##1 !ack ##1 ack)
        else $error("instruction write did not ack after 4 cycles");

    read_latency: assert property (@(posedge clk) disable iff (reset)
        $rose(access) && !we |-> !ack ##1 !ack ##1 ack)
        else $error("read did not ack after 2 cycles");

endmodule

bind micro_core micro_core_checker u_micro_core_checker (
    .clk   (clk),
    .reset (reset),
    .cyc   (cyc),
    .stb   (stb),
    .we    (we),
    .adr   (adr),
    .ack   (ack)
);

// ==== tb/micro_core_tb.sv ====
module micro_core_tb import micro_pkg::*; ();

    typedef struct packed {
        word_t    insn;
        reg_idx_t rd;
        word_t    value;
        logic     no_write;                 // Register keeps its old value
        logic     clear;                    // Status write before the instruction
        logic     ill;                      // Illegal flag expected afterwards
    } row_t;

    logic    clk;
    logic    reset;
    logic    cyc;
    logic    stb;
    logic    we;
    wb_adr_t adr;
    word_t   dat_w;
    word_t   dat_r;
    logic    ack;

    row_t  rows[$];
    word_t model [32];                      // Expected register contents
    int    errors;

    micro_core u_micro_core (
        .clk   (clk),
        .reset (reset),
        .cyc   (cyc),
        .stb   (stb),
        .we    (we),
        .adr   (adr),
        .dat_w (dat_w),
        .dat_r (dat_r),
        .ack   (ack)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    function automatic word_t r_insn(logic [6:0] f7, reg_idx_t rs2, reg_idx_t rs1,
                                     logic [2:0] f3, reg_idx_t rd, logic [6:0] op);
        return {f7, rs2, rs1, f3, rd, op};
    endfunction

    function automatic word_t i_insn(logic [11:0] imm, reg_idx_t rs1, logic [2:0] f3,
                                     reg_idx_t rd, logic [6:0] op);
        return {imm, rs1, f3, rd, op};
    endfunction

    function automatic word_t lui(logic [19:0] imm, reg_idx_t rd);
        return {imm, rd, 7'b0110111};
    endfunction

    task automatic expect_write(word_t insn, word_t value, logic ill = 1'b0,
                                logic clear = 1'b0);
        rows.push_back(row_t'{insn, insn[11:7], value, 1'b0, clear, ill});
    endtask

    task automatic expect_illegal(word_t insn);
        rows.push_back(row_t'{insn, insn[11:7], 32'd0, 1'b1, 1'b0, 1'b1});
    endtask

    task automatic build_table();
        // Constants x1..x5
        expect_write(lui(20'h12345, 5'd1), 32'h12345000);
        expect_write(i_insn(12'h678, 5'd1, 3'b000, 5'd1, 7'b0010011), 32'h12345678);
        expect_write(i_insn(12'hFF8, 5'd0, 3'b000, 5'd2, 7'b0010011), 32'hFFFFFFF8);
        expect_write(i_insn(12'd5, 5'd0, 3'b000, 5'd3, 7'b0010011), 32'd5);
        expect_write(lui(20'h80000, 5'd4), 32'h80000000);
        expect_write(i_insn(12'h7FF, 5'd0, 3'b000, 5'd5, 7'b0010011), 32'h000007FF);
        // R-type group and MUL
        expect_write(r_insn(7'h00, 5'd3, 5'd1, 3'b000, 5'd6, 7'b0110011), 32'h1234567D);
        expect_write(r_insn(7'h20, 5'd2, 5'd3, 3'b000, 5'd7, 7'b0110011), 32'h0000000D);
        expect_write(r_insn(7'h00, 5'd5, 5'd1, 3'b111, 5'd8, 7'b0110011), 32'h00000678);
        expect_write(r_insn(7'h00, 5'd3, 5'd2, 3'b110, 5'd9, 7'b0110011), 32'hFFFFFFFD);
        expect_write(r_insn(7'h00, 5'd2, 5'd1, 3'b100, 5'd10, 7'b0110011), 32'hEDCBA980);
        expect_write(r_insn(7'h00, 5'd3, 5'd3, 3'b001, 5'd11, 7'b0110011), 32'h000000A0);
        expect_write(r_insn(7'h00, 5'd3, 5'd4, 3'b101, 5'd12, 7'b0110011), 32'h04000000);
        expect_write(r_insn(7'h20, 5'd3, 5'd4, 3'b101, 5'd13, 7'b0110011), 32'hFC000000);
        expect_write(r_insn(7'h00, 5'd3, 5'd2, 3'b010, 5'd14, 7'b0110011), 32'd1);
        expect_write(r_insn(7'h00, 5'd3, 5'd2, 3'b011, 5'd15, 7'b0110011), 32'd0);
        expect_write(r_insn(7'h00, 5'd2, 5'd3, 3'b010, 5'd16, 7'b0110011), 32'd0);
        expect_write(r_insn(7'h00, 5'd2, 5'd3, 3'b011, 5'd17, 7'b0110011), 32'd1);
        expect_write(r_insn(7'h01, 5'd3, 5'd1, 3'b000, 5'd18, 7'b0110011), 32'h5B05B058);
        expect_write(r_insn(7'h01, 5'd1, 5'd2, 3'b000, 5'd19, 7'b0110011), 32'h6E5D4C40);
        // I-type group
        expect_write(i_insn(12'd100, 5'd2, 3'b000, 5'd20, 7'b0010011), 32'h0000005C);
        expect_write(i_insn(12'hFFF, 5'd2, 3'b010, 5'd21, 7'b0010011), 32'd1);
        expect_write(i_insn(12'hFFF, 5'd3, 3'b011, 5'd22, 7'b0010011), 32'd1);
        expect_write(i_insn(12'hFFF, 5'd1, 3'b100, 5'd23, 7'b0010011), 32'hEDCBA987);
        expect_write(i_insn(12'h0F0, 5'd3, 3'b110, 5'd24, 7'b0010011), 32'h000000F5);
        expect_write(i_insn(12'h0FF, 5'd1, 3'b111, 5'd25, 7'b0010011), 32'h00000078);
        expect_write(i_insn(12'h004, 5'd1, 3'b001, 5'd26, 7'b0010011), 32'h23456780);
        expect_write(i_insn(12'h01C, 5'd2, 3'b101, 5'd27, 7'b0010011), 32'h0000000F);
        expect_write(i_insn(12'h402, 5'd2, 3'b101, 5'd28, 7'b0010011), 32'hFFFFFFFE);
        expect_write(i_insn(12'h01F, 5'd4, 3'b101, 5'd29, 7'b0010011), 32'd1);
        // x0 stays zero
        expect_write(i_insn(12'd7, 5'd3, 3'b000, 5'd0, 7'b0010011), 32'd0);
        expect_write(r_insn(7'h00, 5'd1, 5'd1, 3'b000, 5'd0, 7'b0110011), 32'd0);
        // Load, branch, XOR with funct7 = 1, unknown opcode
        expect_illegal(i_insn(12'd0, 5'd1, 3'b010, 5'd6, 7'b0000011));
        expect_illegal(r_insn(7'h00, 5'd3, 5'd3, 3'b000, 5'd7, 7'b1100011));
        expect_illegal(r_insn(7'h01, 5'd3, 5'd1, 3'b100, 5'd8, 7'b0110011));
        expect_illegal(i_insn(12'd0, 5'd1, 3'b000, 5'd9, 7'b1111111));
        expect_write(i_insn(12'd42, 5'd0, 3'b000, 5'd31, 7'b0010011), 32'd42, 1'b1);
        expect_write(i_insn(12'd1, 5'd3, 3'b000, 5'd30, 7'b0010011), 32'd6, 1'b0, 1'b1);
    endtask

    task automatic wait_ack(string what);
        int cycles;
        cycles = 0;
        do begin
            @(negedge clk);
            cycles++;
        end while (!ack && cycles < 20);
        if (!ack) begin
            $display("Timeout: no ack within 20 cycles for %s", what);
            errors++;
        end
    endtask

    task automatic wb_write(wb_adr_t a, word_t d);
        @(posedge clk);
        cyc   <= 1'b1;
        stb   <= 1'b1;
        we    <= 1'b1;
        adr   <= a;
        dat_w <= d;
        wait_ack("a write");
        @(posedge clk);
        cyc <= 1'b0;
        stb <= 1'b0;
        we  <= 1'b0;
    endtask

    task automatic wb_read(wb_adr_t a, output word_t d);
        @(posedge clk);
        cyc <= 1'b1;
        stb <= 1'b1;
        we  <= 1'b0;
        adr <= a;
        wait_ack("a read");
        d = dat_r;                          // Stable at the falling edge
        @(posedge clk);
        cyc <= 1'b0;
        stb <= 1'b0;
    endtask

    task automatic read_reg(reg_idx_t idx, output word_t d);
        wb_read(WB_ADR_REG_BASE | {1'b0, idx}, d);
    endtask

    initial begin
        word_t got;
        word_t exp;
        errors = 0;
        reset  = 1'b1;
        cyc    = 1'b0;
        stb    = 1'b0;
        we     = 1'b0;
        adr    = '0;
        dat_w  = '0;
        for (int i = 0; i < 32; i++) begin
            model[i] = '0;
        end
        build_table();
        repeat (10) @(posedge clk);
        reset <= 1'b0;

        for (int n = 1; n < 32; n++) begin
            read_reg(reg_idx_t'(n), got);
            if (got !== 32'd0) begin
                $display("error %0t reset x%0d expected 0 got %h", $time, n, got);
                errors++;
            end
        end
        wb_read(WB_ADR_STATUS, got);
        if (got !== 32'd0) begin
            $display("error %0t reset status expected 0 got %h", $time, got);
            errors++;
        end

        foreach (rows[i]) begin
            if (rows[i].clear)
                wb_write(WB_ADR_STATUS, '0);
            wb_write(WB_ADR_INSN, rows[i].insn);
            if (!rows[i].no_write)
                model[rows[i].rd] = rows[i].value;
            exp = model[rows[i].rd];
            read_reg(rows[i].rd, got);
            if (got !== exp) begin
                $display("error %0t row %0d x%0d expected %h got %h",
                         $time, i, rows[i].rd, exp, got);
                errors++;
            end
            wb_read(WB_ADR_STATUS, got);
            if (got !== {31'b0, rows[i].ill}) begin
                $display("error %0t row %0d status expected %h got %h",
                         $time, i, {31'b0, rows[i].ill}, got);
                errors++;
            end
        end

        $display("Error count: %0d", errors);
        if (errors == 0)
            $display("No errors");
        else
            $display("Errors found");
        $finish;
    end

endmodule

// ==== filelist.f ====
hw/micro_pkg.sv
hw/address_mapper.sv
hw/control_store.sv
hw/alu.sv
hw/register_file.sv
hw/micro_sequencer.sv
hw/micro_core.sv
tb/micro_core_checker.sv
tb/micro_core_tb.sv

// ==== Makefile ====
VERILATOR = verilator
VFLAGS    = --binary --timing --assert
TOP       = micro_core_tb
FILELIST  = filelist.f
OBJ_DIR   = obj_dir
LOG       = sim.log

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	-./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1
	cat $(LOG)
	grep -qx "No errors" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
